/* design/pe_adder.sv */
`timescale 1ns/1ps
`include "vec_pe_defines.svh"

// integer adder on the second half of the pipe
// operands arrive aligned with the multiplier result
module pe_adder (
    input  logic                 clk,
    input  logic                 i_reset,
    input  vec_pe_pkg::pe_op_e   i_op,     // op delayed by PE_HALF
    input  logic                 i_skip_d, // skip delayed by PE_HALF
    input  vec_pe_pkg::pe_beat_t i_a_d,
    input  vec_pe_pkg::pe_beat_t i_b_d,
    input  vec_pe_pkg::pe_beat_t i_c_d,
    input  vec_pe_pkg::pe_beat_t i_mul,
    output vec_pe_pkg::pe_beat_t o_add
);

    import vec_pe_pkg::*;

    logic [`PE_DWIDTH-1:0] opnd_x;
    logic [`PE_DWIDTH-1:0] opnd_y;
    logic                  sel_valid;
    logic                  sel_last;
    pe_beat_t              sum_q; // first add stage

    // operand and strobe choice by the aligned op
    always_comb begin
        opnd_x    = i_a_d.data;
        opnd_y    = i_b_d.data;
        sel_last  = i_a_d.last;
        sel_valid = 1'b0; // MUL, NOP and spare codes never use the adder
        case (i_op)
            ADD: begin
                sel_valid = i_a_d.valid & i_b_d.valid;
            end
            ACC: begin
                opnd_x    = i_b_d.data;
                opnd_y    = i_c_d.data;
                // skip drops the leading beat, c is valid once the pipe has filled
                sel_valid = i_a_d.valid & i_b_d.valid & i_c_d.valid & ~i_skip_d;
            end
            MACC: begin
                opnd_x    = i_mul.data;
                opnd_y    = i_c_d.data;
                sel_valid = i_mul.valid & i_c_d.valid; // product already gated
                sel_last  = i_mul.last;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            sum_q <= '0;
        end else begin
            sum_q.valid <= sel_valid;
            sum_q.last  <= sel_last;
            sum_q.data  <= opnd_x + opnd_y; // wraps mod 2^32
        end
    end

    // rest of the add half
    stage_delay #(
        .T     (pe_beat_t),
        .DEPTH (`PE_HALF - 1)
    ) u_sum_pipe (
        .clk     (clk),
        .i_reset (i_reset),
        .i_in    (sum_q),
        .o_out   (o_add)
    );

endmodule

/* design/pe_multiplier.sv */
`timescale 1ns/1ps
`include "vec_pe_defines.svh"

// integer multiplier, PE_HALF cycles from operands to product
module pe_multiplier (
    input  logic                 clk,
    input  logic                 i_reset,
    input  vec_pe_pkg::pe_op_e   i_op,
    input  vec_pe_pkg::pe_beat_t i_a,
    input  vec_pe_pkg::pe_beat_t i_b,
    output vec_pe_pkg::pe_beat_t o_mul
);

    import vec_pe_pkg::*;

    logic                  mul_en;   // beat belongs to the mul path
    pe_beat_t              a_q;      // stage 1, carries valid/last
    logic [`PE_DWIDTH-1:0] b_data_q; // stage 1, second operand
    pe_beat_t              prod_q;   // stage 2, product

    assign mul_en = (i_op == MUL) || (i_op == MACC);

    // stage 1 registers the operands
    always_ff @(posedge clk) begin
        if (i_reset) begin
            a_q      <= '0;
            b_data_q <= '0;
        end else begin
            a_q.valid <= i_a.valid & i_b.valid & mul_en; // both operands needed
            a_q.last  <= i_a.last;                       // already or'ed by the top
            a_q.data  <= i_a.data;
            b_data_q  <= i_b.data;
        end
    end

    // stage 2 multiplies, upper half of the product is dropped
    always_ff @(posedge clk) begin
        if (i_reset) begin
            prod_q <= '0;
        end else begin
            prod_q.valid <= a_q.valid;
            prod_q.last  <= a_q.last;
            prod_q.data  <= a_q.data * b_data_q; // 32-bit context, wraps
        end
    end

    // remaining stages just carry the result
    stage_delay #(
        .T     (pe_beat_t),
        .DEPTH (`PE_HALF - 2)
    ) u_tail (
        .clk     (clk),
        .i_reset (i_reset),
        .i_in    (prod_q),
        .o_out   (o_mul)
    );

endmodule

/* design/pe_output_stage.sv */
`timescale 1ns/1ps
`include "vec_pe_defines.svh"

// brings mul and bypass up to full latency, then picks the result
module pe_output_stage (
    input  logic                 clk,
    input  logic                 i_reset,
    input  vec_pe_pkg::pe_op_e   i_op_d,   // half-delayed op
    input  vec_pe_pkg::pe_beat_t i_add,    // already at full latency
    input  vec_pe_pkg::pe_beat_t i_mul,    // half latency
    input  vec_pe_pkg::pe_beat_t i_bypass, // half-delayed beat a
    output vec_pe_pkg::pe_beat_t o_beat
);

    import vec_pe_pkg::*;

    pe_op_e   op_dd;    // fully delayed op
    pe_beat_t mul_d;
    pe_beat_t bypass_d;

    stage_delay #(.T(pe_op_e), .DEPTH(`PE_HALF)) u_op_delay (
        .clk     (clk),
        .i_reset (i_reset),
        .i_in    (i_op_d),
        .o_out   (op_dd)
    );

    stage_delay #(.T(pe_beat_t), .DEPTH(`PE_HALF)) u_mul_delay (
        .clk     (clk),
        .i_reset (i_reset),
        .i_in    (i_mul),
        .o_out   (mul_d)
    );

    stage_delay #(.T(pe_beat_t), .DEPTH(`PE_HALF)) u_bypass_delay (
        .clk     (clk),
        .i_reset (i_reset),
        .i_in    (i_bypass),
        .o_out   (bypass_d)
    );

    // plain mux, no register on the add path
    always_comb begin
        case (op_dd)
            ADD, ACC, MACC: o_beat = i_add;
            MUL:            o_beat = mul_d;
            default:        o_beat = bypass_d; // NOP and codes 5..7
        endcase
    end

endmodule

/* design/stage_delay.sv */
`timescale 1ns/1ps

// fixed-depth shift register, payload type set per instance
module stage_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic i_reset,
    input  T     i_in,
    output T     o_out
);

    T pipe [DEPTH]; // pipe[0] is the youngest entry

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= T'(0); // flush, clears valid bits in beat payloads
            end
        end else begin
            pipe[0] <= i_in;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign o_out = pipe[DEPTH-1]; // exactly DEPTH edges after i_in

endmodule

/* design/vec_pe_defines.svh */
`ifndef VEC_PE_DEFINES_SVH
`define VEC_PE_DEFINES_SVH

// data word width, integer lanes wrap mod 2^32
`define PE_DWIDTH 32

// input beat to output beat, same for every op
`define PE_LATENCY 8

// multiply half and add half share the latency evenly
`define PE_HALF (`PE_LATENCY / 2)

`endif

/* design/vec_pe_pkg.sv */
`include "vec_pe_defines.svh"

package vec_pe_pkg;

    // per-beat operation code
    // codes 5..7 are not named and fall through to the NOP path
    typedef enum logic [2:0] {
        ADD  = 3'd0, // a + b
        ACC  = 3'd1, // b + c, first beat may be skipped
        MUL  = 3'd2, // a * b, low word kept
        MACC = 3'd3, // a * b + c
        NOP  = 3'd4  // a passed through
    } pe_op_e;

    // one stream beat, last and valid ride along with the word
    typedef struct packed {
        logic                  last;
        logic                  valid;
        logic [`PE_DWIDTH-1:0] data;
    } pe_beat_t;

endpackage

/* design/vec_pe_top.sv */
`timescale 1ns/1ps
`include "vec_pe_defines.svh"

// vector PE, one beat per cycle in, result PE_LATENCY cycles later
module vec_pe_top (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic [`PE_DWIDTH-1:0] i_a,
    input  logic [`PE_DWIDTH-1:0] i_b,
    input  logic [`PE_DWIDTH-1:0] i_c,
    input  logic                  i_valid_a,
    input  logic                  i_valid_b,
    input  logic                  i_last_a,
    input  logic                  i_last_b,
    input  logic                  i_skip,
    input  vec_pe_pkg::pe_op_e    i_op,
    output logic [`PE_DWIDTH-1:0] o_data,
    output logic                  o_valid,
    output logic                  o_last
);

    import vec_pe_pkg::*;

    pe_beat_t beat_a, beat_b, beat_c;
    pe_beat_t a_d, b_d, c_d;          // aligned with mul_beat
    pe_op_e   op_d;
    logic     skip_d;
    pe_beat_t mul_beat, add_beat, out_beat;

    assign beat_a = '{last: i_last_a | i_last_b, valid: i_valid_a, data: i_a}; // last of either stream
    assign beat_b = '{last: 1'b0, valid: i_valid_b, data: i_b};
    assign beat_c = '{last: 1'b0, valid: 1'b1, data: i_c};                     // c is always valid

    // half-latency copies for the add half
    stage_delay #(.T(pe_beat_t), .DEPTH(`PE_HALF)) u_a_delay (clk, i_reset, beat_a, a_d);
    stage_delay #(.T(pe_beat_t), .DEPTH(`PE_HALF)) u_b_delay (clk, i_reset, beat_b, b_d);
    stage_delay #(.T(pe_beat_t), .DEPTH(`PE_HALF)) u_c_delay (clk, i_reset, beat_c, c_d);
    stage_delay #(.T(pe_op_e), .DEPTH(`PE_HALF)) u_op_delay (clk, i_reset, i_op, op_d);
    stage_delay #(.T(logic), .DEPTH(`PE_HALF)) u_skip_delay (clk, i_reset, i_skip, skip_d);

    pe_multiplier u_mul (
        .clk (clk), .i_reset (i_reset), .i_op (i_op),
        .i_a (beat_a), .i_b (beat_b), .o_mul (mul_beat)
    );

    pe_adder u_add (
        .clk (clk), .i_reset (i_reset), .i_op (op_d), .i_skip_d (skip_d),
        .i_a_d (a_d), .i_b_d (b_d), .i_c_d (c_d), .i_mul (mul_beat), .o_add (add_beat)
    );

    pe_output_stage u_out (
        .clk (clk), .i_reset (i_reset), .i_op_d (op_d), .i_add (add_beat),
        .i_mul (mul_beat), .i_bypass (a_d), .o_beat (out_beat)
    );

    assign o_data  = out_beat.data;
    assign o_valid = out_beat.valid;
    assign o_last  = out_beat.last;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, judge the log
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module vec_pe_tb \
    -f vec_pe.f -Mdir obj_dir -o vec_pe_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vec_pe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail, see $LOG"
exit 1

/* tb/vec_pe_assert.sv */
`timescale 1ns/1ps
`include "vec_pe_defines.svh"

// protocol checks, bound into every vec_pe_top
module vec_pe_assert (
    input logic                  clk,
    input logic                  i_reset,
    input vec_pe_pkg::pe_op_e    i_op,
    input logic                  i_valid_a,
    input logic [`PE_DWIDTH-1:0] i_a,
    input logic                  o_valid,
    input logic [`PE_DWIDTH-1:0] o_data
);

    import vec_pe_pkg::*;

    localparam int LAT = `PE_LATENCY;

    logic nop_in;    // valid beat entering the bypass path
    int   n_err = 0; // failed assertions so far

    assign nop_in = i_valid_a && (i_op == NOP);

    // pipe is empty one cycle after reset
    a_reset_clears: assert property (@(posedge clk) i_reset |=> !o_valid)
        else begin
            $error("o_valid high in the cycle after reset");
            n_err++;
        end

    // bypass beat comes out after exactly LAT edges
    a_nop_latency: assert property (
        @(posedge clk) disable iff (i_reset) nop_in |-> ##LAT o_valid
    ) else begin
        $error("valid NOP beat missing at the output after PE_LATENCY cycles");
        n_err++;
    end

    a_nop_data: assert property (
        @(posedge clk) disable iff (i_reset) nop_in |-> ##LAT (o_data == $past(i_a, LAT))
    ) else begin
        $error("NOP beat data changed on the way through");
        n_err++;
    end

endmodule

bind vec_pe_top vec_pe_assert u_vec_pe_assert (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_op      (i_op),
    .i_valid_a (i_valid_a),
    .i_a       (i_a),
    .o_valid   (o_valid),
    .o_data    (o_data)
);

/* tb/vec_pe_tb.sv */
`timescale 1ns/1ps
`include "vec_pe_defines.svh"

module vec_pe_tb;

    import vec_pe_pkg::*;

    localparam int LAT         = `PE_LATENCY;
    localparam int DRAIN_LIMIT = 4 * `PE_LATENCY; // pipe never holds more than LAT beats

    // expected output beat tagged with the cycle it was driven in
    typedef struct {
        int unsigned           cyc;
        logic                  valid;
        logic                  last;
        logic [`PE_DWIDTH-1:0] data;
    } exp_t;

    logic                  clk = 1'b0;
    logic                  i_reset;
    logic [`PE_DWIDTH-1:0] i_a, i_b, i_c;
    logic                  i_valid_a, i_valid_b;
    logic                  i_last_a, i_last_b;
    logic                  i_skip;
    pe_op_e                i_op;
    logic [`PE_DWIDTH-1:0] o_data;
    logic                  o_valid;
    logic                  o_last;

    exp_t        exp_q[$];          // beats in flight, oldest first
    int unsigned cycle     = 0;     // rising edges so far
    int          n_pass    = 0;
    int          n_fail    = 0;     // comparator side
    int          n_timeout = 0;     // stimulus side
    int          test_base;
    string       cur_test  = "reset";
    logic [31:0] rng_state = 32'd96;

    vec_pe_top u_vec_pe_top (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_a       (i_a),
        .i_b       (i_b),
        .i_c       (i_c),
        .i_valid_a (i_valid_a),
        .i_valid_b (i_valid_b),
        .i_last_a  (i_last_a),
        .i_last_b  (i_last_b),
        .i_skip    (i_skip),
        .i_op      (i_op),
        .o_data    (o_data),
        .o_valid   (o_valid),
        .o_last    (o_last)
    );

    always #4 clk = ~clk; // 8 ns period

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // xorshift32 step on the shared state
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // expected result of one input beat with integer ops wrapping mod 2^32
    function automatic exp_t ref_beat(input pe_op_e op, input logic [31:0] a,
                                      input logic [31:0] b, input logic [31:0] c,
                                      input logic va, input logic vb,
                                      input logic la, input logic lb, input logic skip);
        exp_t e;
        e.cyc   = 0;
        e.last  = la | lb;    // last of either stream for every op
        e.valid = va & vb;    // two-operand ops
        e.data  = a;
        case (op)
            ADD:  e.data = a + b;
            ACC: begin
                e.data  = b + c;
                e.valid = va & vb & ~skip; // skipped beat comes out invalid
            end
            MUL:  e.data = a * b;          // low word of the product
            MACC: e.data = a * b + c;
            default: e.valid = va;         // NOP and spare codes pass a through
        endcase
        return e;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %h, actual %h", what, expected, actual);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    // every failure so far including bound assertions
    function automatic int error_count();
        return n_fail + n_timeout + u_vec_pe_top.u_vec_pe_assert.n_err;
    endfunction

    function automatic void idle_inputs();
        i_a       = '0;
        i_b       = '0;
        i_c       = '0;
        i_valid_a = 1'b0;
        i_valid_b = 1'b0;
        i_last_a  = 1'b0;
        i_last_b  = 1'b0;
        i_skip    = 1'b0;
        i_op      = NOP;   // invalid bypass beat never shows up as valid
    endfunction

    // one beat per call and back to back when called in a row
    task automatic drive_beat(input pe_op_e op, input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] c, input logic va, input logic vb,
                              input logic la, input logic lb, input logic skip);
        exp_t e;
        @(posedge clk);
        #1;
        i_op      = op;
        i_a       = a;
        i_b       = b;
        i_c       = c;
        i_valid_a = va;
        i_valid_b = vb;
        i_last_a  = la;
        i_last_b  = lb;
        i_skip    = skip;
        e         = ref_beat(op, a, b, c, va, vb, la, lb, skip);
        e.cyc     = cycle;
        exp_q.push_back(e);
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_base = error_count();
    endtask

    // idle the inputs and wait for every expected beat to come out
    task automatic end_test();
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        idle_inputs();
        while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout in %s: %0d expected beats never came out", cur_test, exp_q.size());
            n_timeout++;
            exp_q.delete();
        end
        $display("test %s done, %0d errors", cur_test, error_count() - test_base);
    endtask

    // outputs are stable at the falling edge
    // an early valid output is matched against the oldest beat
    always @(negedge clk) begin : compare_beat
        exp_t e;
        if (!i_reset) begin
            if (exp_q.size() > 0 && (exp_q[0].cyc + LAT <= cycle || o_valid === 1'b1)) begin
                e = exp_q.pop_front();
                check_eq({cur_test, " arrival cycle"}, e.cyc + LAT, cycle);
                check_eq({cur_test, " o_valid"}, 32'(e.valid), 32'(o_valid));
                check_eq({cur_test, " o_last"}, 32'(e.last), 32'(o_last));
                if (e.valid) begin
                    check_eq({cur_test, " o_data"}, e.data, o_data);
                end
            end else if (o_valid !== 1'b0) begin
                $display("%s: o_valid high at cycle %0d with no beat due", cur_test, cycle);
                n_fail++;
            end
        end
    end

    initial begin
        i_reset = 1'b1;
        idle_inputs();
        repeat (4) @(posedge clk);
        #1;
        i_reset = 1'b0;

        begin_test("add_stream");
        for (int i = 0; i < 20; i++) begin
            drive_beat(ADD, next_rand(), next_rand(), next_rand(), 1'b1, 1'b1, i == 19, 1'b0, 1'b0);
        end
        end_test();

        begin_test("mul_macc");
        drive_beat(MUL, 32'hFFFF_FFFF, 32'h0000_0002, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        drive_beat(MACC, 32'h8000_0001, 32'h0001_0003, 32'hFFFF_FFF0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 16; i++) begin
            drive_beat(i[0] ? MACC : MUL, next_rand(), next_rand(), next_rand(),
                       1'b1, 1'b1, i == 15, 1'b0, 1'b0);
        end
        end_test();

        begin_test("acc_skip");
        for (int i = 0; i < 10; i++) begin
            drive_beat(ACC, next_rand(), next_rand(), next_rand(), 1'b1, 1'b1, 1'b0, i == 9, i == 0);
        end
        end_test();

        begin_test("mixed_ops");
        for (int i = 0; i < 30; i++) begin
            logic [31:0] r;
            r = next_rand();
            drive_beat(pe_op_e'(3'(i % 5)), next_rand(), next_rand(), next_rand(),
                       r[0], r[1], r[2] & r[3], r[4] & r[5], r[6]);
        end
        end_test();

        begin_test("nop_latency");
        drive_beat(NOP, 32'hC0DE_1234, 32'h5555_AAAA, 32'h0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        end_test();

        begin_test("reset_flush");
        for (int i = 0; i < 6; i++) begin
            drive_beat(ADD, next_rand(), next_rand(), next_rand(), 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        end
        @(posedge clk);
        #1;
        i_reset = 1'b1;     // beats in flight are dropped
        idle_inputs();
        exp_q.delete();
        repeat (4) @(posedge clk);
        #1;
        i_reset = 1'b0;
        repeat (2 * LAT) @(posedge clk); // comparator flags any stray valid here
        for (int i = 0; i < 5; i++) begin
            drive_beat(i[0] ? MUL : ADD, next_rand(), next_rand(), next_rand(),
                       1'b1, 1'b1, i == 4, 1'b0, 1'b0);
        end
        end_test();

        $display("checks passed %0d, failed %0d", n_pass, error_count());
        if (error_count() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* vec_pe.f */
+incdir+design
design/vec_pe_pkg.sv
design/stage_delay.sv
design/pe_multiplier.sv
design/pe_adder.sv
design/pe_output_stage.sv
design/vec_pe_top.sv
tb/vec_pe_assert.sv
tb/vec_pe_tb.sv
